//--- build.f
rtl/cachePkg.sv
rtl/reqLatch.sv
rtl/cacheCtrl.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/memPort.sv
rtl/dCache.sv
test/tbMemModel.sv
test/tbDCache.sv

//--- rtl/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic reqValid_i,
  input  wire logic isWrite_i,
  input  wire logic hit_i,
  input  wire logic victimDirty_i,
  input  wire logic memRdReady_i,
  input  wire logic memWrReady_i,
  input  wire logic memBeatLast_i,
  input  wire logic memBeatValid_i,
  output logic      addrOk_o,
  output logic      dataOk_o,
  output logic      memRdValid_o,
  output logic      memWrValid_o,
  output logic      beatEn_o,
  output logic      refillEn_o,
  output logic      storeEn_o
);

  logic [cachePkg::STATE_W-1:0] state;
  logic [cachePkg::STATE_W-1:0] nextState;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::ST_IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    addrOk_o = 1'b0;
    dataOk_o = 1'b0;
    memRdValid_o = 1'b0;
    memWrValid_o = 1'b0;
    beatEn_o = 1'b0;
    refillEn_o = 1'b0;
    storeEn_o = 1'b0;
    case (state)
      cachePkg::ST_IDLE: begin
        addrOk_o = 1'b1;
        if (reqValid_i) begin
          nextState = cachePkg::ST_COMPARE;
        end
      end
      cachePkg::ST_COMPARE: begin
        if (hit_i) begin
          // completes here and the store merges at the end of this cycle
          dataOk_o = 1'b1;
          storeEn_o = isWrite_i;
          nextState = cachePkg::ST_IDLE;
        end else if (victimDirty_i) begin
          nextState = cachePkg::ST_WRITEBACK;
        end else begin
          nextState = cachePkg::ST_FILLREQ;
        end
      end
      cachePkg::ST_WRITEBACK: begin
        memWrValid_o = 1'b1;
        if (memWrReady_i) begin
          nextState = cachePkg::ST_FILLREQ;
        end
      end
      cachePkg::ST_FILLREQ: begin
        memRdValid_o = 1'b1;
        if (memRdReady_i) begin
          nextState = cachePkg::ST_GETDATA;
        end
      end
      cachePkg::ST_GETDATA: begin
        // beats may arrive with gaps
        beatEn_o = memBeatValid_i;
        if (memBeatValid_i && memBeatLast_i) begin
          nextState = cachePkg::ST_REFILL;
        end
      end
      cachePkg::ST_REFILL: begin
        refillEn_o = 1'b1;
        nextState = cachePkg::ST_COMPARE;
      end
      default: begin
        nextState = cachePkg::ST_IDLE;
      end
    endcase
  end

  // a refilled line must hit on the following compare
  refillHits: assert property (@(posedge clk) disable iff (!rst_n)
    refillEn_o |=> hit_i);

endmodule

`default_nettype wire

//--- rtl/cachePkg.sv
`default_nettype none

package cachePkg;

  // address and datapath widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 64;
  localparam int LINE_W = 256;

  // 2-way, 64 sets, 32-byte lines
  localparam int TAG_W = 21;
  localparam int INDEX_W = 6;
  localparam int OFFSET_W = 5;
  localparam int SETS = 64;

  // refill runs in four 64-bit beats
  localparam int BEATS = 4;
  localparam int BEAT_CNT_W = 2;
  localparam int MASK_W = 8;

  // controller state codes
  localparam int STATE_W = 3;
  localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
  localparam logic [STATE_W-1:0] ST_COMPARE = 3'd1;
  localparam logic [STATE_W-1:0] ST_WRITEBACK = 3'd2;
  localparam logic [STATE_W-1:0] ST_FILLREQ = 3'd3;
  localparam logic [STATE_W-1:0] ST_GETDATA = 3'd4;
  localparam logic [STATE_W-1:0] ST_REFILL = 3'd5;

  // one address word, seen raw or split into fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [INDEX_W-1:0] index;
      logic [OFFSET_W-1:0] offset;
    } f;
  } cacheAddr_u;

endpackage

`default_nettype wire

//--- rtl/dCache.sv
`timescale 1ns/1ps
`default_nettype none

module dCache (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          reqValid_i,
  input  wire logic                          reqWrite_i,
  input  wire logic [cachePkg::ADDR_W-1:0]   reqAddr_i,
  input  wire logic [cachePkg::WORD_W-1:0]   wrData_i,
  input  wire logic [cachePkg::MASK_W-1:0]   wrMask_i,
  output logic                               addrOk_o,
  output logic                               dataOk_o,
  output logic [cachePkg::WORD_W-1:0]        rdData_o,
  output logic                               memRdValid_o,
  input  wire logic                          memRdReady_i,
  output logic [cachePkg::ADDR_W-1:0]        memRdAddr_o,
  input  wire logic [cachePkg::WORD_W-1:0]   memBeatData_i,
  input  wire logic                          memBeatValid_i,
  input  wire logic                          memBeatLast_i,
  output logic                               memWrValid_o,
  input  wire logic                          memWrReady_i,
  output logic [cachePkg::ADDR_W-1:0]        memWrAddr_o,
  output logic [cachePkg::LINE_W-1:0]        memWrData_o
);

  cachePkg::cacheAddr_u reqAddr;
  logic isWrite;
  logic [cachePkg::WORD_W-1:0] storeData;
  logic [cachePkg::WORD_W-1:0] storeBitMask;
  logic hit;
  logic hitWay;
  logic victimWay;
  logic victimDirty;
  logic [cachePkg::TAG_W-1:0] victimTag;
  logic beatEn;
  logic refillEn;
  logic storeEn;
  logic [cachePkg::LINE_W-1:0] fillLine;
  logic [cachePkg::LINE_W-1:0] victimLine;

  reqLatch reqLatch_inst (
    .clk(clk), .rst_n(rst_n),
    .accept_i(reqValid_i && addrOk_o),
    .reqWrite_i(reqWrite_i), .reqAddr_i(reqAddr_i),
    .wrData_i(wrData_i), .wrMask_i(wrMask_i),
    .addr_o(reqAddr), .isWrite_o(isWrite),
    .storeData_o(storeData), .storeBitMask_o(storeBitMask)
  );

  cacheCtrl cacheCtrl_inst (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .isWrite_i(isWrite),
    .hit_i(hit), .victimDirty_i(victimDirty),
    .memRdReady_i(memRdReady_i), .memWrReady_i(memWrReady_i),
    .memBeatLast_i(memBeatLast_i), .memBeatValid_i(memBeatValid_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o),
    .memRdValid_o(memRdValid_o), .memWrValid_o(memWrValid_o),
    .beatEn_o(beatEn), .refillEn_o(refillEn), .storeEn_o(storeEn)
  );

  tagStore tagStore_inst (
    .clk(clk), .rst_n(rst_n), .addr_i(reqAddr),
    .refillEn_i(refillEn), .storeEn_i(storeEn),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimTag_o(victimTag)
  );

  // word select is offset bits 4..3
  dataStore dataStore_inst (
    .clk(clk), .index_i(reqAddr.f.index),
    .wordSel_i(reqAddr.f.offset[cachePkg::OFFSET_W-1 -: cachePkg::BEAT_CNT_W]),
    .refillEn_i(refillEn), .storeEn_i(storeEn),
    .victimWay_i(victimWay), .hitWay_i(hitWay),
    .fillLine_i(fillLine), .storeData_i(storeData), .storeBitMask_i(storeBitMask),
    .rdData_o(rdData_o), .victimLine_o(victimLine)
  );

  memPort memPort_inst (
    .clk(clk), .rst_n(rst_n), .addr_i(reqAddr),
    .victimTag_i(victimTag), .beatEn_i(beatEn),
    .memBeatData_i(memBeatData_i), .victimLine_i(victimLine),
    .memRdAddr_o(memRdAddr_o), .memWrAddr_o(memWrAddr_o),
    .memWrData_o(memWrData_o), .fillLine_o(fillLine)
  );

endmodule

`default_nettype wire

//--- rtl/dataStore.sv
`timescale 1ns/1ps
`default_nettype none

module dataStore (
  input  wire logic                              clk,
  input  wire logic [cachePkg::INDEX_W-1:0]      index_i,
  input  wire logic [cachePkg::BEAT_CNT_W-1:0]   wordSel_i,
  input  wire logic                              refillEn_i,
  input  wire logic                              storeEn_i,
  input  wire logic                              victimWay_i,
  input  wire logic                              hitWay_i,
  input  wire logic [cachePkg::LINE_W-1:0]       fillLine_i,
  input  wire logic [cachePkg::WORD_W-1:0]       storeData_i,
  input  wire logic [cachePkg::WORD_W-1:0]       storeBitMask_i,
  output logic [cachePkg::WORD_W-1:0]            rdData_o,
  output logic [cachePkg::LINE_W-1:0]            victimLine_o
);

  logic [cachePkg::LINE_W-1:0] lineArr [2][cachePkg::SETS];
  logic [cachePkg::LINE_W-1:0] hitLine;
  logic [cachePkg::WORD_W-1:0] oldWord;
  logic [cachePkg::WORD_W-1:0] mergedWord;

  assign hitLine = lineArr[hitWay_i][index_i];
  assign oldWord = hitLine[wordSel_i*cachePkg::WORD_W +: cachePkg::WORD_W];

  // keep unmasked bytes, take masked ones from the store
  assign mergedWord = (oldWord & ~storeBitMask_i) | (storeData_i & storeBitMask_i);

  always_ff @(posedge clk) begin
    if (refillEn_i) begin
      lineArr[victimWay_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      lineArr[hitWay_i][index_i][wordSel_i*cachePkg::WORD_W +: cachePkg::WORD_W] <= mergedWord;
    end
  end

  // arrays read combinationally, so the load word is ready in compare
  assign rdData_o = oldWord;

  // write-back always takes the way about to be replaced
  assign victimLine_o = lineArr[victimWay_i][index_i];

endmodule

`default_nettype wire

//--- rtl/memPort.sv
`timescale 1ns/1ps
`default_nettype none

module memPort (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire cachePkg::cacheAddr_u          addr_i,
  input  wire logic [cachePkg::TAG_W-1:0]    victimTag_i,
  input  wire logic                          beatEn_i,
  input  wire logic [cachePkg::WORD_W-1:0]   memBeatData_i,
  input  wire logic [cachePkg::LINE_W-1:0]   victimLine_i,
  output logic [cachePkg::ADDR_W-1:0]        memRdAddr_o,
  output logic [cachePkg::ADDR_W-1:0]        memWrAddr_o,
  output logic [cachePkg::LINE_W-1:0]        memWrData_o,
  output logic [cachePkg::LINE_W-1:0]        fillLine_o
);

  logic [cachePkg::BEAT_CNT_W-1:0] beatCnt;
  logic [cachePkg::LINE_W-1:0] fillBuf;
  cachePkg::cacheAddr_u rdAddr;
  cachePkg::cacheAddr_u wrAddr;

  // beat counter wraps back to zero after the fourth beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatEn_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // low word first
  always_ff @(posedge clk) begin
    if (beatEn_i) begin
      fillBuf[beatCnt*cachePkg::WORD_W +: cachePkg::WORD_W] <= memBeatData_i;
    end
  end

  // line aligned addresses
  always_comb begin
    rdAddr.raw = addr_i.raw;
    rdAddr.f.offset = '0;
    wrAddr.raw = addr_i.raw;
    wrAddr.f.tag = victimTag_i;
    wrAddr.f.offset = '0;
  end

  assign memRdAddr_o = rdAddr.raw;
  assign memWrAddr_o = wrAddr.raw;
  assign memWrData_o = victimLine_i;
  assign fillLine_o = fillBuf;

  // the controller must leave getData on the fourth beat
  noExtraBeat: assert property (@(posedge clk) disable iff (!rst_n)
    (beatEn_i && beatCnt == cachePkg::BEAT_CNT_W'(cachePkg::BEATS - 1)) |=> !beatEn_i);

endmodule

`default_nettype wire

//--- rtl/reqLatch.sv
`timescale 1ns/1ps
`default_nettype none

module reqLatch (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          accept_i,
  input  wire logic                          reqWrite_i,
  input  wire logic [cachePkg::ADDR_W-1:0]   reqAddr_i,
  input  wire logic [cachePkg::WORD_W-1:0]   wrData_i,
  input  wire logic [cachePkg::MASK_W-1:0]   wrMask_i,
  output cachePkg::cacheAddr_u               addr_o,
  output logic                               isWrite_o,
  output logic [cachePkg::WORD_W-1:0]        storeData_o,
  output logic [cachePkg::WORD_W-1:0]        storeBitMask_o
);

  logic [cachePkg::WORD_W-1:0] bitMask;

  // one mask bit per byte lane becomes eight bits
  always_comb begin
    for (int i = 0; i < cachePkg::MASK_W; i++) begin
      bitMask[i*8 +: 8] = {8{wrMask_i[i]}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_o.raw <= '0;
      isWrite_o <= 1'b0;
    end else if (accept_i) begin
      addr_o.raw <= reqAddr_i;
      isWrite_o <= reqWrite_i;
    end
  end

  // store payload is already lane aligned
  always_ff @(posedge clk) begin
    if (accept_i) begin
      storeData_o <= wrData_i;
      storeBitMask_o <= bitMask;
    end
  end

endmodule

`default_nettype wire

//--- rtl/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire cachePkg::cacheAddr_u addr_i,
  input  wire logic             refillEn_i,
  input  wire logic             storeEn_i,
  output logic                  hit_o,
  output logic                  hitWay_o,
  output logic                  victimWay_o,
  output logic                  victimDirty_o,
  output logic [cachePkg::TAG_W-1:0] victimTag_o
);

  logic [cachePkg::TAG_W-1:0] tagArr [2][cachePkg::SETS];
  logic [1:0][cachePkg::SETS-1:0] validArr;
  logic [1:0][cachePkg::SETS-1:0] dirtyArr;
  logic [cachePkg::SETS-1:0] victimBits;
  logic [cachePkg::INDEX_W-1:0] idx;
  logic [1:0] wayHit;

  assign idx = addr_i.f.index;

  // compare both ways at once
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validArr[w][idx] && (tagArr[w][idx] == addr_i.f.tag);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];
  assign victimWay_o = victimBits[idx];
  assign victimDirty_o = dirtyArr[victimBits[idx]][idx];
  assign victimTag_o = tagArr[victimBits[idx]][idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      dirtyArr <= '0;
      victimBits <= '0;
    end else if (refillEn_i) begin
      // new line is clean and the next refill goes to the other way
      validArr[victimBits[idx]][idx] <= 1'b1;
      dirtyArr[victimBits[idx]][idx] <= 1'b0;
      victimBits[idx] <= ~victimBits[idx];
    end else if (storeEn_i) begin
      dirtyArr[wayHit[1]][idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refillEn_i) begin
      tagArr[victimBits[idx]][idx] <= addr_i.f.tag;
    end
  end

  oneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(wayHit[0] && wayHit[1]));

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tbDCache -f build.f
./obj_dir/VtbDCache

//--- test/tbDCache.sv
`timescale 1ns/1ps
`default_nettype none

module tbDCache;

  localparam int WAIT_LIMIT = 200;
  // A, C and D share index 2 while B sits at index 4
  localparam logic [31:0] LINE_A = 32'h0000_1040;
  localparam logic [31:0] LINE_B = 32'h0000_2080;
  localparam logic [31:0] LINE_C = LINE_A + 32'h0000_0800;
  localparam logic [31:0] LINE_D = LINE_A + 32'h0000_1000;

  logic clk = 1'b0;
  logic rst_n;
  logic reqValid;
  logic reqWrite;
  logic [cachePkg::ADDR_W-1:0] reqAddr;
  logic [cachePkg::WORD_W-1:0] wrData;
  logic [cachePkg::MASK_W-1:0] wrMask;
  logic addrOk;
  logic dataOk;
  logic [cachePkg::WORD_W-1:0] rdData;
  logic memRdValid;
  logic memRdReady;
  logic [cachePkg::ADDR_W-1:0] memRdAddr;
  logic [cachePkg::WORD_W-1:0] memBeatData;
  logic memBeatValid;
  logic memBeatLast;
  logic memWrValid;
  logic memWrReady;
  logic [cachePkg::ADDR_W-1:0] memWrAddr;
  logic [cachePkg::LINE_W-1:0] memWrData;
  int rdCount;
  int wrCount;
  logic [cachePkg::ADDR_W-1:0] lastRdAddr;
  logic [cachePkg::ADDR_W-1:0] lastWrAddr;
  logic [cachePkg::LINE_W-1:0] lastWrLine;

  // expected processor view of the stored words
  logic [cachePkg::WORD_W-1:0] shadow [logic [28:0]];

  always #10 clk = ~clk;

  dCache dCache_inst (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqWrite_i(reqWrite), .reqAddr_i(reqAddr),
    .wrData_i(wrData), .wrMask_i(wrMask),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .memRdValid_o(memRdValid), .memRdReady_i(memRdReady), .memRdAddr_o(memRdAddr),
    .memBeatData_i(memBeatData), .memBeatValid_i(memBeatValid),
    .memBeatLast_i(memBeatLast),
    .memWrValid_o(memWrValid), .memWrReady_i(memWrReady),
    .memWrAddr_o(memWrAddr), .memWrData_o(memWrData)
  );

  tbMemModel memModel_inst (
    .clk(clk),
    .memRdValid_i(memRdValid), .memRdReady_o(memRdReady), .memRdAddr_i(memRdAddr),
    .memBeatData_o(memBeatData), .memBeatValid_o(memBeatValid),
    .memBeatLast_o(memBeatLast),
    .memWrValid_i(memWrValid), .memWrReady_o(memWrReady),
    .memWrAddr_i(memWrAddr), .memWrData_i(memWrData),
    .rdCount_o(rdCount), .lastRdAddr_o(lastRdAddr),
    .wrCount_o(wrCount), .lastWrAddr_o(lastWrAddr), .lastWrLine_o(lastWrLine)
  );

  function automatic logic [63:0] patternWord(input logic [31:0] addr);
    return {{3'b000, addr[31:3]} ^ 32'h5A5A_0F0F, ~{addr[31:3], 3'b011}};
  endfunction

  function automatic logic [63:0] expectWord(input logic [31:0] addr);
    if (shadow.exists(addr[31:3])) begin
      return shadow[addr[31:3]];
    end
    return patternWord(addr);
  endfunction

  function automatic logic [63:0] mergeBytes(input logic [63:0] old,
      input logic [63:0] data, input logic [7:0] mask);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < cachePkg::MASK_W; i++) begin
      if (mask[i]) begin
        res[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // lines are 32 bytes
  function automatic cachePkg::cacheAddr_u lineAddr(input logic [31:0] addr);
    cachePkg::cacheAddr_u la;
    la.raw = addr & ~32'h0000_001F;
    return la;
  endfunction

  function automatic logic [255:0] expectLine(input logic [31:0] addr);
    logic [255:0] line;
    cachePkg::cacheAddr_u base;
    base = lineAddr(addr);
    for (int b = 0; b < cachePkg::BEATS; b++) begin
      line[b*cachePkg::WORD_W +: cachePkg::WORD_W] = expectWord(base.raw + 32'(b * 8));
    end
    return line;
  endfunction

  task automatic stopRun();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkWord(input string what, input logic [cachePkg::WORD_W-1:0] got,
      input logic [cachePkg::WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic checkLine(input string what, input logic [cachePkg::LINE_W-1:0] got,
      input logic [cachePkg::LINE_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic checkAddr(input string what, input cachePkg::cacheAddr_u got,
      input cachePkg::cacheAddr_u exp);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h (tag %h index %0d), expected %h", $time, what,
        got.raw, got.f.tag, got.f.index, exp.raw);
      stopRun();
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // one request that returns the read word and the cycles waited after acceptance
  task automatic access(input logic write, input logic [31:0] addr, input logic [63:0] data,
      input logic [7:0] mask, output logic [63:0] word, output int waitCycles);
    int n;
    n = 0;
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    wrData = data;
    wrMask = mask;
    while (!addrOk) begin
      nextCycle();
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout: request to %h was never accepted", addr);
        stopRun();
      end
    end
    nextCycle();
    reqValid = 1'b0;
    waitCycles = 0;
    while (!dataOk) begin
      nextCycle();
      waitCycles++;
      if (waitCycles > WAIT_LIMIT) begin
        $display("timeout: request to %h never completed", addr);
        stopRun();
      end
    end
    word = rdData;
  endtask

  task automatic load(input logic [31:0] addr, input logic miss);
    logic [63:0] word;
    int cycles;
    int reads;
    reads = rdCount;
    access(1'b0, addr, '0, '0, word, cycles);
    checkWord($sformatf("load %h", addr), word, expectWord(addr));
    checkFlag($sformatf("load %h read request count", addr),
      rdCount == reads + (miss ? 1 : 0), 1'b1);
    if (miss) begin
      checkAddr("refill address", lastRdAddr, lineAddr(addr));
    end else begin
      checkFlag("hit done one cycle after accept", cycles == 0, 1'b1);
    end
  endtask

  task automatic store(input logic [31:0] addr, input logic [63:0] data,
      input logic [7:0] mask, input logic miss);
    logic [63:0] word;
    int cycles;
    int reads;
    reads = rdCount;
    access(1'b1, addr, data, mask, word, cycles);
    checkFlag($sformatf("store %h read request count", addr),
      rdCount == reads + (miss ? 1 : 0), 1'b1);
    if (!miss) begin
      checkFlag("store hit done one cycle after accept", cycles == 0, 1'b1);
    end
    shadow[addr[31:3]] = mergeBytes(expectWord(addr), data, mask);
  endtask

  task automatic resetValues();
    checkFlag("addrOk after reset", addrOk, 1'b1);
    checkFlag("dataOk after reset", dataOk, 1'b0);
    checkFlag("memRdValid after reset", memRdValid, 1'b0);
    checkFlag("memWrValid after reset", memWrValid, 1'b0);
  endtask

  task automatic missFill();
    load(LINE_A + 32'h08, 1'b1);
  endtask

  task automatic sameLineHits();
    load(LINE_A + 32'h18, 1'b0);
    load(LINE_A, 1'b0);
  endtask

  task automatic storeMerge();
    store(LINE_A + 32'h10, 64'h1122_3344_5566_7788, 8'h0F, 1'b0);
    load(LINE_A + 32'h10, 1'b0);
    // store miss refills first
    store(LINE_B + 32'h08, 64'hCAFE_F00D_DEAD_BEEF, 8'hF0, 1'b1);
    load(LINE_B + 32'h08, 1'b0);
  endtask

  task automatic dirtyEviction();
    int writes;
    store(LINE_A, 64'hA1B2_C3D4_E5F6_0718, 8'h81, 1'b0);
    writes = wrCount;
    // C fills way 1 and D then replaces way 0 which holds dirty A
    load(LINE_C + 32'h08, 1'b1);
    checkFlag("clean fill wrote back", wrCount != writes, 1'b0);
    load(LINE_D, 1'b1);
    checkFlag("dirty victim written back once", wrCount == writes + 1, 1'b1);
    checkAddr("write-back address", lastWrAddr, lineAddr(LINE_A));
    checkLine("write-back line", lastWrLine, expectLine(LINE_A));
  endtask

  task automatic refetchEvicted();
    int writes;
    writes = wrCount;
    load(LINE_A + 32'h10, 1'b1);
    load(LINE_A, 1'b0);
    load(LINE_A + 32'h08, 1'b0);
    checkFlag("refetch wrote back", wrCount != writes, 1'b0);
  endtask

  initial begin
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    wrData = '0;
    wrMask = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    resetValues();
    missFill();
    sameLineHits();
    storeMerge();
    dirtyEviction();
    refetchEvicted();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tbMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemModel (
  input  wire logic                         clk,
  input  wire logic                         memRdValid_i,
  output logic                              memRdReady_o,
  input  wire logic [cachePkg::ADDR_W-1:0]  memRdAddr_i,
  output logic [cachePkg::WORD_W-1:0]       memBeatData_o,
  output logic                              memBeatValid_o,
  output logic                              memBeatLast_o,
  input  wire logic                         memWrValid_i,
  output logic                              memWrReady_o,
  input  wire logic [cachePkg::ADDR_W-1:0]  memWrAddr_i,
  input  wire logic [cachePkg::LINE_W-1:0]  memWrData_i,
  output int                                rdCount_o,
  output logic [cachePkg::ADDR_W-1:0]       lastRdAddr_o,
  output int                                wrCount_o,
  output logic [cachePkg::ADDR_W-1:0]       lastWrAddr_o,
  output logic [cachePkg::LINE_W-1:0]       lastWrLine_o
);

  localparam int SEED = 22117;
  localparam int MAX_READY_DELAY = 3;
  localparam int MAX_BEAT_GAP = 2;

  // memory contents keyed by word address
  logic [cachePkg::WORD_W-1:0] words [logic [28:0]];

  // every address bit shapes a never-written word
  function automatic logic [63:0] patternWord(input logic [28:0] wa);
    return {{3'b000, wa} ^ 32'h5A5A_0F0F, ~{wa, 3'b011}};
  endfunction

  function automatic logic [63:0] readWord(input logic [28:0] wa);
    if (words.exists(wa)) begin
      return words[wa];
    end
    return patternWord(wa);
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic serveWriteBack();
    logic [28:0] wa;
    repeat ($urandom_range(MAX_READY_DELAY)) nextCycle();
    memWrReady_o = 1'b1;
    wa = memWrAddr_i[31:3];
    for (int b = 0; b < cachePkg::BEATS; b++) begin
      words[wa + 29'(b)] = memWrData_i[b*cachePkg::WORD_W +: cachePkg::WORD_W];
    end
    lastWrAddr_o = memWrAddr_i;
    lastWrLine_o = memWrData_i;
    wrCount_o++;
    nextCycle();
    memWrReady_o = 1'b0;
  endtask

  task automatic serveRead();
    logic [28:0] wa;
    repeat ($urandom_range(MAX_READY_DELAY)) nextCycle();
    memRdReady_o = 1'b1;
    wa = memRdAddr_i[31:3];
    lastRdAddr_o = memRdAddr_i;
    rdCount_o++;
    nextCycle();
    memRdReady_o = 1'b0;
    // low word first with random gaps between beats
    for (int b = 0; b < cachePkg::BEATS; b++) begin
      repeat ($urandom_range(MAX_BEAT_GAP)) nextCycle();
      memBeatValid_o = 1'b1;
      memBeatLast_o = (b == cachePkg::BEATS - 1);
      memBeatData_o = readWord(wa + 29'(b));
      nextCycle();
      memBeatValid_o = 1'b0;
      memBeatLast_o = 1'b0;
    end
  endtask

  initial begin
    memRdReady_o = 1'b0;
    memWrReady_o = 1'b0;
    memBeatData_o = '0;
    memBeatValid_o = 1'b0;
    memBeatLast_o = 1'b0;
    rdCount_o = 0;
    wrCount_o = 0;
    lastRdAddr_o = '0;
    lastWrAddr_o = '0;
    lastWrLine_o = '0;
    void'($urandom(SEED));
    forever begin
      nextCycle();
      if (memWrValid_i) begin
        serveWriteBack();
      end else if (memRdValid_i) begin
        serveRead();
      end
    end
  end

endmodule

`default_nettype wire
